/* design/muldivPkg.sv */
// widths, latency, M-extension opcode fields, result select enum and packet structs
package muldivPkg;

    // datapath sizing
    localparam int DATA_WIDTH = 32;
    localparam int LATENCY    = 4;   // input edge to wbPacket_o, in cycles

    // instruction field values for RV32M
    localparam logic [6:0] OP_OP      = 7'b0110011;
    localparam logic [6:0] FN7_MULDIV = 7'b0000001;

    localparam logic [2:0] FN3_MUL    = 3'b000;
    localparam logic [2:0] FN3_MULH   = 3'b001;
    localparam logic [2:0] FN3_MULHSU = 3'b010;
    localparam logic [2:0] FN3_MULHU  = 3'b011;
    localparam logic [2:0] FN3_DIV    = 3'b100;
    localparam logic [2:0] FN3_DIVU   = 3'b101;
    localparam logic [2:0] FN3_REM    = 3'b110;
    localparam logic [2:0] FN3_REMU   = 3'b111;

    typedef logic [DATA_WIDTH-1:0] data_t;   // operand / result word
    typedef logic [31:0]           inst_t;   // raw instruction
    typedef logic [7:0]            seqNo_t;  // program order tag
    typedef logic [6:0]            phyReg_t; // physical dest register

    // which datapath output goes to writeback
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_PROD_LO,
        SEL_PROD_HI,
        SEL_QUOT,
        SEL_REM
    } resultSel_e;

    typedef struct packed {
        logic executed;
        logic exception;   // divide by zero
        logic destValid;
    } exeFlags_t;

    // issued instruction with operands
    typedef struct packed {
        logic    valid;
        seqNo_t  seqNo;
        phyReg_t phyDest;
        logic    phyDestValid;
        inst_t   inst;
        data_t   src1;
        data_t   src2;
    } exePkt_t;

    // result packet to the register file / active list
    typedef struct packed {
        logic      valid;
        seqNo_t    seqNo;
        phyReg_t   phyDest;
        exeFlags_t flags;
        data_t     destData;
    } wbPkt_t;

    // control riding alongside the datapaths
    typedef struct packed {
        logic       valid;
        seqNo_t     seqNo;
        phyReg_t    phyDest;
        exeFlags_t  flags;
        resultSel_e sel;
    } tagPkt_t;

endpackage

/* design/muldivDecode.sv */
// M-extension decode: result select, operand signedness, flags and divide-by-zero exception
module muldivDecode
    import muldivPkg::*;
(
    input  exePkt_t exePacket_i,
    output tagPkt_t decTag_o,
    output logic    mulSigned1_o,   // sign extend src1 into the multiplier
    output logic    mulSigned2_o,   // sign extend src2 into the multiplier
    output logic    divSigned_o
);

    logic [6:0] opcode;
    logic [2:0] fn3;
    logic [6:0] fn7;
    logic       isMulDiv;     // valid M instruction
    logic       isDivRem;
    logic       divByZero;
    resultSel_e sel;
    exeFlags_t  flags;

    // standard R-type field positions
    assign opcode   = exePacket_i.inst[6:0];
    assign fn3      = exePacket_i.inst[14:12];
    assign fn7      = exePacket_i.inst[31:25];

    assign isMulDiv  = exePacket_i.valid && (opcode == OP_OP) && (fn7 == FN7_MULDIV);
    assign divByZero = (exePacket_i.src2 == '0);

    always_comb
    begin
        sel          = SEL_NONE;  // non-M ops write back zero
        mulSigned1_o = 1'b0;
        mulSigned2_o = 1'b0;
        divSigned_o  = 1'b0;
        if (isMulDiv)
        begin
            case (fn3)
                FN3_MUL:    sel = SEL_PROD_LO;  // low half same for any signedness
                FN3_MULH:
                begin
                    sel          = SEL_PROD_HI;
                    mulSigned1_o = 1'b1;
                    mulSigned2_o = 1'b1;
                end
                FN3_MULHSU:
                begin
                    sel          = SEL_PROD_HI;
                    mulSigned1_o = 1'b1;   // rs1 signed, rs2 unsigned
                end
                FN3_MULHU:  sel = SEL_PROD_HI;
                FN3_DIV:
                begin
                    sel         = SEL_QUOT;
                    divSigned_o = 1'b1;
                end
                FN3_DIVU:   sel = SEL_QUOT;
                FN3_REM:
                begin
                    sel         = SEL_REM;
                    divSigned_o = 1'b1;
                end
                default:    sel = SEL_REM;  // FN3_REMU
            endcase
        end
    end

    assign isDivRem = (sel == SEL_QUOT) || (sel == SEL_REM);

    always_comb
    begin
        flags.executed  = isMulDiv;
        flags.destValid = isMulDiv && exePacket_i.phyDestValid;
        flags.exception = isDivRem && divByZero;   // result still defined, core traps
        decTag_o.valid   = exePacket_i.valid;
        decTag_o.seqNo   = exePacket_i.seqNo;
        decTag_o.phyDest = exePacket_i.phyDest;
        decTag_o.flags   = flags;
        decTag_o.sel     = sel;
    end

    // an exception can only come from an executed M instruction
    excNeedsExec: assert final (!decTag_o.flags.exception || decTag_o.flags.executed)
        else $error("decode raised exception on a non-executed instruction");

endmodule

/* design/multiplierPipe.sv */
// 33x33 signed multiplier with per-operand sign control, registered over LATENCY-1 stages
module multiplierPipe
    import muldivPkg::*;
(
    input  logic            clk,
    input  data_t           src1_i,
    input  data_t           src2_i,
    input  logic            signed1_i,
    input  logic            signed2_i,
    output data_t [1:0]     product_o    // [1] high word, [0] low word
);

    localparam int STAGES = LATENCY - 1;  // last edge belongs to writeback

    logic signed [DATA_WIDTH:0]     opA;        // 33 bit, extended by sign control
    logic signed [DATA_WIDTH:0]     opB;
    logic signed [2*DATA_WIDTH+1:0] fullProduct;
    data_t [1:0]                    prodPipe [STAGES];

    // top bit is the sign when signed, zero otherwise
    assign opA = {signed1_i & src1_i[DATA_WIDTH-1], src1_i};
    assign opB = {signed2_i & src2_i[DATA_WIDTH-1], src2_i};

    // one signed multiply covers MUL, MULH, MULHSU and MULHU
    assign fullProduct = opA * opB;

    // plain shift chain, no enable and no reset
    always_ff @(posedge clk)
    begin
        prodPipe[0] <= fullProduct[2*DATA_WIDTH-1:0];  // upper two bits are sign copies
        for (int i = 1; i < STAGES; i++)
        begin
            prodPipe[i] <= prodPipe[i-1];
        end
    end

    assign product_o = prodPipe[STAGES-1];

endmodule

/* design/dividerPipe.sv */
// signed/unsigned divider with RISC-V zero-divisor and overflow results, LATENCY-1 stages
module dividerPipe
    import muldivPkg::*;
(
    input  logic  clk,
    input  data_t src1_i,       // dividend
    input  data_t src2_i,       // divisor
    input  logic  signed_i,
    output data_t quotient_o,
    output data_t remainder_o
);

    localparam int STAGES = LATENCY - 1;

    typedef struct packed {
        data_t quotient;
        data_t remainder;
    } divRes_t;

    logic    negDividend;
    logic    negDivisor;
    logic    divByZero;
    logic    overflow;       // most negative / -1
    data_t   absDividend;
    data_t   absDivisor;
    data_t   safeDivisor;
    data_t   uQuot;
    data_t   uRem;
    divRes_t result;
    divRes_t divPipe [STAGES];

    // magnitudes for the unsigned core
    assign negDividend = signed_i & src1_i[DATA_WIDTH-1];
    assign negDivisor  = signed_i & src2_i[DATA_WIDTH-1];
    assign absDividend = negDividend ? -src1_i : src1_i;
    assign absDivisor  = negDivisor  ? -src2_i : src2_i;

    assign divByZero = (src2_i == '0);
    assign overflow  = signed_i && (src1_i == {1'b1, {(DATA_WIDTH-1){1'b0}}})
                       && (src2_i == '1);

    // keep the core free of x on a zero divisor, result overridden below
    assign safeDivisor = divByZero ? data_t'(1) : absDivisor;
    assign uQuot       = absDividend / safeDivisor;
    assign uRem        = absDividend % safeDivisor;

    always_comb
    begin
        if (divByZero)
        begin
            result.quotient  = '1;          // all ones, signed or not
            result.remainder = src1_i;
        end
        else if (overflow)
        begin
            result.quotient  = src1_i;
            result.remainder = '0;
        end
        else
        begin
            // truncate toward zero, remainder takes dividend sign
            result.quotient  = (negDividend ^ negDivisor) ? -uQuot : uQuot;
            result.remainder = negDividend ? -uRem : uRem;
        end
    end

    always_ff @(posedge clk)
    begin
        divPipe[0] <= result;
        for (int i = 1; i < STAGES; i++)
        begin
            divPipe[i] <= divPipe[i-1];
        end
    end

    assign quotient_o  = divPipe[STAGES-1].quotient;
    assign remainder_o = divPipe[STAGES-1].remainder;

endmodule

/* design/writebackStage.sv */
// tag pipeline with recovery kill, result select and registered writeback packet
module writebackStage
    import muldivPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        recoverFlag_i,
    input  tagPkt_t     decTag_i,
    input  data_t [1:0] product_i,
    input  data_t       quotient_i,
    input  data_t       remainder_i,
    output wbPkt_t      wbPacket_o
);

    localparam int STAGES = LATENCY - 1;  // matches datapath depth

    tagPkt_t tagPipe [STAGES];
    tagPkt_t tailTag;       // tag aligned with datapath outputs
    data_t   selData;

    assign tailTag = tagPipe[STAGES-1];

    // pick the datapath result for this op
    always_comb
    begin
        case (tailTag.sel)
            SEL_PROD_LO: selData = product_i[0];
            SEL_PROD_HI: selData = product_i[1];
            SEL_QUOT:    selData = quotient_i;
            SEL_REM:     selData = remainder_i;
            default:     selData = '0;    // non-M op
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < STAGES; i++)
            begin
                tagPipe[i] <= '0;
            end
            wbPacket_o <= '0;
        end
        else if (recoverFlag_i)
        begin
            // kill everything in flight, including the tag entering now
            for (int i = 0; i < STAGES; i++)
            begin
                tagPipe[i] <= '0;
            end
            wbPacket_o <= '0;   // tail tag dies too
        end
        else
        begin
            tagPipe[0] <= decTag_i;
            for (int i = 1; i < STAGES; i++)
            begin
                tagPipe[i] <= tagPipe[i-1];
            end
            if (tailTag.valid)
            begin
                wbPacket_o.valid    <= 1'b1;
                wbPacket_o.seqNo    <= tailTag.seqNo;
                wbPacket_o.phyDest  <= tailTag.phyDest;
                wbPacket_o.flags    <= tailTag.flags;
                wbPacket_o.destData <= selData;
            end
            else
            begin
                wbPacket_o <= '0;   // bubble
            end
        end
    end

    // idle or killed slots leave nothing behind on the bus
    idleIsZero: assert property (@(posedge clk) disable iff (reset)
        !wbPacket_o.valid |-> (wbPacket_o == '0))
        else $error("wbPacket_o not zero while invalid");

    execNeedsValid: assert property (@(posedge clk) disable iff (reset)
        wbPacket_o.flags.executed |-> wbPacket_o.valid)
        else $error("executed flag set on invalid writeback");

endmodule

/* design/complexAlu.sv */
// multiply/divide unit top: decode, multiplier, divider and writeback stage
module complexAlu
    import muldivPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    recoverFlag_i,
    input  exePkt_t exePacket_i,
    output wbPkt_t  wbPacket_o
);

    tagPkt_t     decTag;
    logic        mulSigned1;
    logic        mulSigned2;
    logic        divSigned;
    data_t [1:0] product;       // LATENCY-1 edges after issue
    data_t       quotient;
    data_t       remainder;

    muldivDecode u_muldivDecode (
        .exePacket_i  (exePacket_i),
        .decTag_o     (decTag),
        .mulSigned1_o (mulSigned1),
        .mulSigned2_o (mulSigned2),
        .divSigned_o  (divSigned)
    );

    multiplierPipe u_multiplierPipe (
        .clk       (clk),
        .src1_i    (exePacket_i.src1),
        .src2_i    (exePacket_i.src2),
        .signed1_i (mulSigned1),
        .signed2_i (mulSigned2),
        .product_o (product)
    );

    dividerPipe u_dividerPipe (
        .clk         (clk),
        .src1_i      (exePacket_i.src1),
        .src2_i      (exePacket_i.src2),
        .signed_i    (divSigned),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    // final edge, registered packet out
    writebackStage u_writebackStage (
        .clk           (clk),
        .reset         (reset),
        .recoverFlag_i (recoverFlag_i),
        .decTag_i      (decTag),
        .product_i     (product),
        .quotient_i    (quotient),
        .remainder_i   (remainder),
        .wbPacket_o    (wbPacket_o)
    );

endmodule

/* bench/clockGen.sv */
// free-running testbench clock source, period 20
module clockGen
(
    output logic clk_o
);

    localparam int HALF_PERIOD = 10;

    // low at time 0, first rising edge at 10
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule

/* bench/aluRefModel.svh */
// RV32M reference functions: 64-bit product, divide results and expected writeback packet
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// exact result from 64-bit arithmetic, special cases straight from the ISA
function automatic data_t refResult(input logic [2:0] fn3, input data_t a, input data_t b);
    logic signed [63:0] sa;     // sign extended
    logic signed [63:0] sb;
    logic signed [63:0] zb;     // b zero extended, used as a signed operand
    logic        [63:0] ua;
    logic        [63:0] ub;
    logic        [63:0] full;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    zb = ub;
    if (fn3[2] && (b == '0))
        return fn3[1] ? a : '1;  // rem keeps dividend, div gives all ones
    case (fn3)
        FN3_MUL:    full = ua * ub;
        FN3_MULH:   full = sa * sb;
        FN3_MULHSU: full = sa * zb;
        FN3_MULHU:  full = ua * ub;
        FN3_DIV:    full = sa / sb;   // min / -1 wraps back to min in the low word
        FN3_DIVU:   full = ua / ub;
        FN3_REM:    full = sa % sb;
        default:    full = ua % ub;
    endcase
    if ((fn3 == FN3_MUL) || fn3[2])
        return full[31:0];
    return full[63:32];  // high product
endfunction

// packet the unit should write back for one issued instruction
function automatic wbPkt_t expectedWriteback(input exePkt_t p);
    wbPkt_t     wb;
    logic       isM;
    logic [2:0] fn3;
    wb  = '0;
    fn3 = p.inst[14:12];
    isM = (p.inst[6:0] == OP_OP) && (p.inst[31:25] == FN7_MULDIV);
    if (p.valid)
    begin
        wb.valid   = 1'b1;
        wb.seqNo   = p.seqNo;
        wb.phyDest = p.phyDest;
        if (isM)  // non-M ops keep zero flags and data
        begin
            wb.flags.executed  = 1'b1;
            wb.flags.destValid = p.phyDestValid;
            wb.flags.exception = fn3[2] && (p.src2 == '0);
            wb.destData        = refResult(fn3, p.src1, p.src2);
        end
    end
    return wb;
endfunction

`endif

/* bench/complexAluTb.sv */
// testbench for complexAlu: random RV32M traffic, recovery pulses, scoreboard queue, timeout
module complexAluTb
    import muldivPkg::*;
();

    localparam int          NUM_SLOTS      = 400;
    localparam int          TIMEOUT_CYCLES = NUM_SLOTS + LATENCY + 4 + 50;
    localparam logic [31:0] SEED           = 32'h2da2_d99e;

    // one expected writeback with the edge it is due on
    typedef struct packed {
        wbPkt_t      pkt;
        logic [31:0] dueEdge;
        logic        killed;
    } expEntry_t;

    logic        clk;
    logic        reset;
    logic        recoverFlag;
    exePkt_t     exePacket;
    wbPkt_t      wbPacket;
    expEntry_t   expQ [$];      // in-flight results, oldest first
    int          edgeNo;        // rising edges seen by the stimulus loop
    int          cycleCount = 0;
    seqNo_t      nextSeq;

    `include "aluRefModel.svh"

    clockGen u_clockGen (
        .clk_o (clk)
    );

    complexAlu u_complexAlu (
        .clk           (clk),
        .reset         (reset),
        .recoverFlag_i (recoverFlag),
        .exePacket_i   (exePacket),
        .wbPacket_o    (wbPacket)
    );

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected)
            stopRun($sformatf("error: time %0t, %s expected %0h, got %0h",
                              $time, name, expected, actual));
    endtask

    task automatic checkPacket(input wbPkt_t expected);
        checkValue("wbPacket_o.valid", wbPacket.valid, expected.valid);
        checkValue("wbPacket_o.seqNo", wbPacket.seqNo, expected.seqNo);
        checkValue("wbPacket_o.phyDest", wbPacket.phyDest, expected.phyDest);
        checkValue("wbPacket_o.flags", wbPacket.flags, expected.flags);
        checkValue("wbPacket_o.destData", wbPacket.destData, expected.destData);
    endtask

    // zero unless the oldest entry is due on this edge
    task automatic checkOutput();
        wbPkt_t expected;
        expected = '0;
        if ((expQ.size() > 0) && (expQ[0].dueEdge == 32'(edgeNo)))
        begin
            if (!expQ[0].killed)
                expected = expQ[0].pkt;
            expQ.delete(0);
        end
        checkPacket(expected);
    endtask

    // corner values often, plain random otherwise
    function automatic data_t pickOperand();
        int pick;
        pick = $urandom_range(15, 0);
        case (pick)
            0:       return '0;
            1:       return 32'h8000_0000;
            2:       return '1;
            3:       return -data_t'($urandom_range(16, 1));  // small negative
            4:       return data_t'($urandom_range(16, 0));
            default: return $urandom;
        endcase
    endfunction

    task automatic driveSlot();
        exePkt_t    pkt;
        expEntry_t  entry;
        int         kind;
        logic [2:0] fn3;
        logic [6:0] fn7;
        logic [6:0] opcode;
        kind   = $urandom_range(99, 0);
        fn3    = 3'($urandom);
        fn7    = FN7_MULDIV;
        opcode = OP_OP;
        pkt.valid        = (kind >= 6);     // a few idle slots
        pkt.seqNo        = nextSeq;
        pkt.phyDest      = 7'($urandom);
        pkt.phyDestValid = 1'($urandom);
        pkt.src1         = pickOperand();
        pkt.src2         = pickOperand();
        if ((kind >= 6) && (kind < 14))
        begin
            if (kind[0])
            begin
                fn7 = kind[1] ? 7'b0100000 : 7'b0000000;  // base ALU ops on OP
            end
            else
            begin
                opcode = 7'($urandom);
                if (opcode == OP_OP)
                    opcode = 7'b0010011;   // OP-IMM
            end
        end
        else if ((kind >= 14) && (kind < 18))
        begin
            fn3      = {1'b1, 2'($urandom)};   // forced zero divisor
            pkt.src2 = '0;
        end
        else if ((kind >= 18) && (kind < 21))
        begin
            fn3      = {1'b1, 1'($urandom), 1'b0};   // signed overflow, DIV or REM
            pkt.src1 = 32'h8000_0000;
            pkt.src2 = '1;
        end
        pkt.inst = {fn7, 5'($urandom), 5'($urandom), fn3, 5'($urandom), opcode};
        if (kind < 6)
            pkt.inst = $urandom;   // garbage with valid low
        exePacket   = pkt;
        recoverFlag = ($urandom_range(99, 0) < 3);
        if (pkt.valid)
        begin
            entry.pkt     = expectedWriteback(pkt);
            entry.dueEdge = 32'(edgeNo + LATENCY);
            entry.killed  = 1'b0;
            expQ.push_back(entry);
            nextSeq++;
        end
        // recovery takes everything still queued, the new entry included
        if (recoverFlag)
        begin
            for (int i = 0; i < expQ.size(); i++)
                expQ[i].killed = 1'b1;
        end
    endtask

    // hard cycle limit
    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES)
            stopRun("timeout: the run did not finish within the cycle limit");
    end

    initial
    begin
        void'($urandom(SEED));
        reset       = 1'b1;
        recoverFlag = 1'b0;
        exePacket   = '0;
        edgeNo      = 0;
        nextSeq     = '0;
        repeat (4)   // output zero from the first edge in reset
        begin
            @(negedge clk);
            edgeNo++;
            checkPacket('0);
        end
        reset = 1'b0;
        repeat (NUM_SLOTS)
        begin
            @(negedge clk);
            edgeNo++;
            checkOutput();   // sample first, then drive
            driveSlot();
        end
        repeat (LATENCY + 2)   // drain with idle inputs
        begin
            @(negedge clk);
            edgeNo++;
            checkOutput();
            recoverFlag = 1'b0;
            exePacket   = '0;
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* complexAlu.f */
+incdir+bench
design/muldivPkg.sv
design/muldivDecode.sv
design/multiplierPipe.sv
design/dividerPipe.sv
design/writebackStage.sv
design/complexAlu.sv
bench/clockGen.sv
bench/complexAluTb.sv
